//--- src/dec_pkg.sv
// Common constants, opcode classes and slot records for the decode stage and its testbench
package dec_pkg;

    localparam int ADDR_BITS    = 32;                   // Width of every pc
    localparam int FETCH_BITS   = 64;                   // Fetch window from the fetch unit
    localparam int DEC_SLOTS    = 2;                    // Halfword slots decoded per block
    localparam int HIST_BLOCKS  = 2;                    // Older blocks kept besides current
    localparam int HIST_ENTRIES = DEC_SLOTS * (HIST_BLOCKS + 1);

    localparam logic [ADDR_BITS-1:0] EMPTY_PC = '1;     // Odd value, so never a real pc

    // Major opcodes of the RV32I subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [3:0] {
        OP_NONE,                                        // Illegal or empty
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_ALU_IMM,
        OP_ALU
    } op_class_e;

    typedef enum logic [1:0] {
        MEM_B,
        MEM_H,
        MEM_W
    } mem_size_e;

    // One halfword slot as handed to a decoder
    typedef struct packed {
        logic [ADDR_BITS-1:0] pc;
        logic [31:0]          bits;                     // Window from this halfword on
        logic                 fault;
    } slot_in_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0] pc;
        logic [31:0]          instr;                    // Upper half zero when compressed
        logic                 compressed;
        op_class_e            op_class;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [31:0]          imm;                      // Sign extended
        logic                 mem_load;
        logic                 mem_store;
        mem_size_e            mem_size;
        logic                 mem_unsigned;
        logic                 illegal;
        logic                 fault;
    } dec_slot_t;

    localparam dec_slot_t DEC_EMPTY = '{
        pc:       EMPTY_PC,
        op_class: OP_NONE,
        mem_size: MEM_B,
        default:  '0
    };

endpackage

//--- src/fetch_slot_feeder.sv
// Holds the current fetch block and hands one halfword slot to each decoder, with the shift strobe
`timescale 1ns/1ps

module fetch_slot_feeder (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic [dec_pkg::ADDR_BITS-1:0]  i_f_pc,
    input  logic [dec_pkg::FETCH_BITS-1:0] i_f_instr,
    input  logic                           i_f_fault,
    input  logic                           i_flush,
    output dec_pkg::slot_in_t              o_slots [dec_pkg::DEC_SLOTS],
    output logic                           o_shift
);
    import dec_pkg::*;

    logic [ADDR_BITS-1:0]  r_pc;
    logic [FETCH_BITS-1:0] r_win;
    logic                  r_fault;
    logic                  new_pc;

    assign new_pc  = (i_f_pc != r_pc);                  // Fetch unit moved on
    assign o_shift = new_pc && (r_pc != EMPTY_PC);      // Current block goes to history

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_pc <= EMPTY_PC;
        end else if (i_flush) begin
            r_pc <= EMPTY_PC;                           // Fetch in this cycle is dropped
        end else if (new_pc) begin
            r_pc <= i_f_pc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (new_pc && !i_flush) begin
            r_win   <= i_f_instr;
            r_fault <= i_f_fault;
        end
    end

    // Slot i starts at halfword i of the window
    for (genvar i = 0; i < DEC_SLOTS; i++) begin : g_out
        assign o_slots[i] = '{
            pc:    (r_pc == EMPTY_PC) ? EMPTY_PC : r_pc + ADDR_BITS'(2 * i),
            bits:  r_win[16*i +: 32],
            fault: r_fault
        };
    end

endmodule

//--- src/slot_decoder.sv
// Combinational decoder for one halfword slot, RV32I subset or RVC subset, into a slot record
`timescale 1ns/1ps

module slot_decoder (
    input  dec_pkg::slot_in_t  i_slot,
    output dec_pkg::dec_slot_t o_dec
);
    import dec_pkg::*;

    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [2:0]  cf3;
    logic        is_rv32;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] cimm_6;
    logic [31:0] cimm_lw;
    logic [31:0] cimm_j;
    logic [4:0]  creg_a;
    logic [4:0]  creg_b;

    assign w       = i_slot.bits;
    assign f3      = w[14:12];
    assign f7      = w[31:25];
    assign cf3     = w[15:13];
    assign is_rv32 = (w[1:0] == 2'b11);

    assign imm_i   = {{20{w[31]}}, w[31:20]};
    assign imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
    assign imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u   = {w[31:12], 12'h000};
    assign imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

    assign cimm_6  = {{26{w[12]}}, w[12], w[6:2]};      // C.ADDI, C.LI
    assign cimm_lw = {25'h0, w[5], w[12:10], w[6], 2'b00};
    assign cimm_j  = {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    assign creg_a  = {2'b01, w[9:7]};                   // rs1' plus 8
    assign creg_b  = {2'b01, w[4:2]};                   // rd' or rs2' plus 8

    always_comb begin
        o_dec            = DEC_EMPTY;
        o_dec.pc         = i_slot.pc;
        o_dec.fault      = i_slot.fault;
        o_dec.compressed = !is_rv32;
        o_dec.instr      = is_rv32 ? w : {16'h0000, w[15:0]};
        if (is_rv32) begin
            case (w[6:0])
                OPC_LUI, OPC_AUIPC: begin
                    o_dec.op_class = (w[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
                    o_dec.rd       = w[11:7];
                    o_dec.imm      = imm_u;
                end
                OPC_JAL: begin
                    o_dec.op_class = OP_JAL;
                    o_dec.rd       = w[11:7];
                    o_dec.imm      = imm_j;
                end
                OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                    if ((w[6:0] == OPC_JALR && f3 == 3'b000)
                        || (w[6:0] == OPC_LOAD && f3 != 3'b011 && f3[2:1] != 2'b11)
                        || (w[6:0] == OPC_OP_IMM && (f3[1:0] != 2'b01
                            || (f7 & {1'b1, !f3[2], 5'h1f}) == 7'h00))) begin
                        o_dec.op_class = (w[6:0] == OPC_JALR) ? OP_JALR :
                                         (w[6:0] == OPC_LOAD) ? OP_LOAD : OP_ALU_IMM;
                        o_dec.rd       = w[11:7];
                        o_dec.rs1      = w[19:15];
                        o_dec.imm      = imm_i;
                    end
                end
                OPC_BRANCH: begin
                    if (f3[2:1] != 2'b01) begin         // BEQ BNE BLT BGE BLTU BGEU
                        o_dec.op_class = OP_BRANCH;
                        o_dec.rs1      = w[19:15];
                        o_dec.rs2      = w[24:20];
                        o_dec.imm      = imm_b;
                    end
                end
                OPC_STORE: begin
                    if (!f3[2] && f3[1:0] != 2'b11) begin
                        o_dec.op_class = OP_STORE;
                        o_dec.rs1      = w[19:15];
                        o_dec.rs2      = w[24:20];
                        o_dec.imm      = imm_s;
                    end
                end
                OPC_OP: begin
                    if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
                        o_dec.op_class = OP_ALU;
                        o_dec.rd       = w[11:7];
                        o_dec.rs1      = w[19:15];
                        o_dec.rs2      = w[24:20];
                    end
                end
                default: ;
            endcase
            if (o_dec.op_class == OP_LOAD || o_dec.op_class == OP_STORE) begin
                o_dec.mem_load     = (o_dec.op_class == OP_LOAD);
                o_dec.mem_store    = (o_dec.op_class == OP_STORE);
                o_dec.mem_size     = mem_size_e'(f3[1:0]);
                o_dec.mem_unsigned = f3[2];             // LBU, LHU
            end
        end else begin
            case ({cf3, w[1:0]})
                5'b000_01, 5'b010_01: begin             // C.ADDI, C.LI
                    o_dec.op_class = OP_ALU_IMM;
                    o_dec.rd       = w[11:7];
                    o_dec.rs1      = cf3[1] ? 5'd0 : w[11:7];
                    o_dec.imm      = cimm_6;
                end
                5'b010_00: begin                        // C.LW
                    o_dec.op_class = OP_LOAD;
                    o_dec.rd       = creg_b;
                    o_dec.rs1      = creg_a;
                    o_dec.imm      = cimm_lw;
                    o_dec.mem_load = 1'b1;
                    o_dec.mem_size = MEM_W;
                end
                5'b110_00: begin                        // C.SW
                    o_dec.op_class  = OP_STORE;
                    o_dec.rs1       = creg_a;
                    o_dec.rs2       = creg_b;
                    o_dec.imm       = cimm_lw;
                    o_dec.mem_store = 1'b1;
                    o_dec.mem_size  = MEM_W;
                end
                5'b101_01: begin                        // C.J
                    o_dec.op_class = OP_JAL;
                    o_dec.imm      = cimm_j;
                end
                5'b100_10: begin
                    if (!w[12] && w[6:2] != 5'd0) begin // C.MV, not C.JR
                        o_dec.op_class = OP_ALU;
                        o_dec.rd       = w[11:7];
                        o_dec.rs2      = w[6:2];
                    end
                end
                default: ;
            endcase
        end
        o_dec.illegal = (o_dec.op_class == OP_NONE);
        if (i_slot.pc == EMPTY_PC) begin
            o_dec = DEC_EMPTY;
        end
    end

endmodule

//--- src/decode_history.sv
// Keeps the current and the older decoded blocks and returns the record that matches the executor pc
`timescale 1ns/1ps

module decode_history (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_flush,
    input  logic                          i_shift,
    input  dec_pkg::dec_slot_t            i_cur [dec_pkg::DEC_SLOTS],
    input  logic [dec_pkg::ADDR_BITS-1:0] i_e_npc,
    output dec_pkg::dec_slot_t            o_dec,
    output logic                          o_hit
);
    import dec_pkg::*;

    dec_slot_t r_hist [HIST_BLOCKS][DEC_SLOTS];         // Index 0 is the newest
    dec_slot_t cand [HIST_ENTRIES];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int b = 0; b < HIST_BLOCKS; b++) begin
                for (int s = 0; s < DEC_SLOTS; s++) begin
                    r_hist[b][s] <= DEC_EMPTY;
                end
            end
        end else if (i_flush) begin
            for (int b = 0; b < HIST_BLOCKS; b++) begin
                for (int s = 0; s < DEC_SLOTS; s++) begin
                    r_hist[b][s] <= DEC_EMPTY;
                end
            end
        end else if (i_shift) begin
            r_hist[0] <= i_cur;
            for (int b = 1; b < HIST_BLOCKS; b++) begin
                r_hist[b] <= r_hist[b-1];              // Oldest block drops out
            end
        end
    end

    // Search order: current block, then history from newest to oldest
    always_comb begin
        for (int s = 0; s < DEC_SLOTS; s++) begin
            cand[s] = i_cur[s];
            for (int b = 0; b < HIST_BLOCKS; b++) begin
                cand[(b + 1) * DEC_SLOTS + s] = r_hist[b][s];
            end
        end
    end

    always_comb begin
        o_dec = DEC_EMPTY;
        o_hit = 1'b0;
        // Walk backwards so the first match in search order wins
        for (int e = HIST_ENTRIES - 1; e >= 0; e--) begin
            if (cand[e].pc == i_e_npc && cand[e].pc != EMPTY_PC) begin
                o_dec = cand[e];
                o_hit = 1'b1;
            end
        end
    end

endmodule

//--- src/instr_decoder.sv
// Top of the decode stage: slot feeder, one decoder per slot and the block history
`timescale 1ns/1ps

module instr_decoder (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic [dec_pkg::ADDR_BITS-1:0]  i_f_pc,      // Fetch block pc
    input  logic [dec_pkg::FETCH_BITS-1:0] i_f_instr,
    input  logic                           i_f_fault,
    input  logic                           i_flush,
    input  logic [dec_pkg::ADDR_BITS-1:0]  i_e_npc,     // Pc wanted by the executor
    output dec_pkg::dec_slot_t             o_dec,
    output logic                           o_hit
);
    import dec_pkg::*;

    slot_in_t  s_slots [DEC_SLOTS];
    dec_slot_t s_dec [DEC_SLOTS];
    logic      s_shift;

    fetch_slot_feeder u_feeder (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_f_pc    (i_f_pc),
        .i_f_instr (i_f_instr),
        .i_f_fault (i_f_fault),
        .i_flush   (i_flush),
        .o_slots   (s_slots),
        .o_shift   (s_shift)
    );

    for (genvar i = 0; i < DEC_SLOTS; i++) begin : g_slot
        slot_decoder u_dec (
            .i_slot (s_slots[i]),
            .o_dec  (s_dec[i])
        );
    end

    decode_history u_hist (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_flush (i_flush),
        .i_shift (s_shift),
        .i_cur   (s_dec),
        .i_e_npc (i_e_npc),
        .o_dec   (o_dec),
        .o_hit   (o_hit)
    );

endmodule

//--- bench/instr_decoder_props.sv
// Concurrent assertions on the selection output, bound into every decode_history instance
`timescale 1ns/1ps

module instr_decoder_props (
    input logic                          i_clk,
    input logic                          i_nrst,
    input logic                          i_flush,
    input dec_pkg::dec_slot_t            i_cur [dec_pkg::DEC_SLOTS],
    input logic [dec_pkg::ADDR_BITS-1:0] i_e_npc,
    input dec_pkg::dec_slot_t            i_dec,
    input logic                          i_hit
);
    import dec_pkg::*;

    logic cur_match;

    always_comb begin
        cur_match = 1'b0;
        for (int s = 0; s < DEC_SLOTS; s++) begin
            if (i_cur[s].pc == i_e_npc && i_cur[s].pc != EMPTY_PC) begin
                cur_match = 1'b1;
            end
        end
    end

    a_hit_pc: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_hit |-> i_dec.pc == i_e_npc)
        else $error("Hit returned a record for another pc");

    a_mem_dir: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_dec.mem_load && i_dec.mem_store))
        else $error("Record is both load and store");

    a_illegal: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_dec.illegal |-> i_dec.op_class == OP_NONE)
        else $error("Illegal record with an opcode class");

    a_flush: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_flush |=> (!i_hit || cur_match))      // Only the new block may hit
        else $error("Hit from history right after flush");

endmodule

bind decode_history instr_decoder_props u_props (
    .i_clk   (i_clk),
    .i_nrst  (i_nrst),
    .i_flush (i_flush),
    .i_cur   (i_cur),
    .i_e_npc (i_e_npc),
    .i_dec   (o_dec),
    .i_hit   (o_hit)
);

//--- include/ref_decode.svh
// Testbench reference decode of one slot, included in the bench module after importing dec_pkg
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

function automatic dec_slot_t ref_decode(input slot_in_t s);
    dec_slot_t   r;
    logic [31:0] x;
    logic [2:0]  f3;
    logic [6:0]  f7;
    x  = s.bits;
    f3 = x[14:12];
    f7 = x[31:25];
    r  = DEC_EMPTY;
    if (s.pc == EMPTY_PC) begin
        return r;
    end
    r.pc         = s.pc;
    r.fault      = s.fault;
    r.compressed = (x[1:0] != 2'b11);
    r.instr      = r.compressed ? {16'h0000, x[15:0]} : x;
    if (!r.compressed) begin
        // Class first, then fields by format
        case (x[6:0])
            OPC_LUI:    r.op_class = OP_LUI;
            OPC_AUIPC:  r.op_class = OP_AUIPC;
            OPC_JAL:    r.op_class = OP_JAL;
            OPC_JALR:   r.op_class = (f3 == 3'd0) ? OP_JALR : OP_NONE;
            OPC_BRANCH: r.op_class = (f3 inside {0, 1, 4, 5, 6, 7}) ? OP_BRANCH : OP_NONE;
            OPC_LOAD:   r.op_class = (f3 inside {0, 1, 2, 4, 5}) ? OP_LOAD : OP_NONE;
            OPC_STORE:  r.op_class = (f3 inside {0, 1, 2}) ? OP_STORE : OP_NONE;
            OPC_OP_IMM: r.op_class = (f3 == 3'd1 && f7 != 7'h00) ? OP_NONE :
                                     (f3 == 3'd5 && !(f7 inside {7'h00, 7'h20})) ? OP_NONE :
                                     OP_ALU_IMM;
            OPC_OP:     r.op_class = (f7 == 7'h00 || (f7 == 7'h20 && f3 inside {0, 5})) ?
                                     OP_ALU : OP_NONE;
            default:    r.op_class = OP_NONE;
        endcase
        if (r.op_class inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_ALU_IMM, OP_ALU}) begin
            r.rd = x[11:7];
        end
        if (r.op_class inside {OP_JALR, OP_LOAD, OP_ALU_IMM, OP_BRANCH, OP_STORE, OP_ALU}) begin
            r.rs1 = x[19:15];
        end
        if (r.op_class inside {OP_BRANCH, OP_STORE, OP_ALU}) begin
            r.rs2 = x[24:20];
        end
        case (r.op_class)
            OP_LUI, OP_AUIPC:            r.imm = {x[31:12], 12'h000};
            OP_JAL:                      r.imm = 32'($signed({x[31], x[19:12], x[20], x[30:21], 1'b0}));
            OP_JALR, OP_LOAD, OP_ALU_IMM: r.imm = 32'($signed(x[31:20]));
            OP_BRANCH:                   r.imm = 32'($signed({x[31], x[7], x[30:25], x[11:8], 1'b0}));
            OP_STORE:                    r.imm = 32'($signed({x[31:25], x[11:7]}));
            default:                     r.imm = 32'h0;
        endcase
        if (r.op_class inside {OP_LOAD, OP_STORE}) begin
            r.mem_load     = (r.op_class == OP_LOAD);
            r.mem_store    = (r.op_class == OP_STORE);
            r.mem_size     = mem_size_e'(f3[1:0]);
            r.mem_unsigned = f3[2];
        end
    end else if (x[1:0] == 2'b01 && x[15:13] inside {3'b000, 3'b010}) begin
        r.op_class = OP_ALU_IMM;
        r.rd       = x[11:7];
        r.rs1      = (x[15:13] == 3'b000) ? x[11:7] : 5'd0;
        r.imm      = 32'($signed({x[12], x[6:2]}));
    end else if (x[1:0] == 2'b00 && x[15:13] inside {3'b010, 3'b110}) begin
        r.op_class  = x[15] ? OP_STORE : OP_LOAD;
        r.mem_load  = !x[15];
        r.mem_store = x[15];
        r.mem_size  = MEM_W;
        r.rs1       = 5'd8 + 5'(x[9:7]);
        r.rd        = x[15] ? 5'd0 : 5'd8 + 5'(x[4:2]);
        r.rs2       = x[15] ? 5'd8 + 5'(x[4:2]) : 5'd0;
        r.imm       = {25'h0, x[5], x[12:10], x[6], 2'b00};
    end else if (x[1:0] == 2'b01 && x[15:13] == 3'b101) begin
        r.op_class = OP_JAL;
        r.imm      = 32'($signed({x[12], x[8], x[10:9], x[6], x[7], x[2], x[11], x[5:3], 1'b0}));
    end else if (x[1:0] == 2'b10 && x[15:12] == 4'b1000 && x[6:2] != 5'd0) begin
        r.op_class = OP_ALU;
        r.rd       = x[11:7];
        r.rs2      = x[6:2];
    end
    r.illegal = (r.op_class == OP_NONE);
    return r;
endfunction

`endif

//--- bench/tb_instr_decoder.sv
// Testbench for the decode stage: random fetch blocks, a block-history model and field checks
`timescale 1ns/1ps

module tb_instr_decoder;
    import dec_pkg::*;

    `include "ref_decode.svh"

    localparam int N_BLOCKS = 300;
    localparam int CLK_NS   = 20;

    typedef struct packed {
        logic [ADDR_BITS-1:0]  pc;
        logic [FETCH_BITS-1:0] win;
        logic                  fault;
    } blk_t;

    logic                  i_clk;
    logic                  i_nrst;
    logic [ADDR_BITS-1:0]  i_f_pc;
    logic [FETCH_BITS-1:0] i_f_instr;
    logic                  i_f_fault;
    logic                  i_flush;
    logic [ADDR_BITS-1:0]  i_e_npc;
    dec_slot_t             o_dec;
    logic                  o_hit;

    integer               seed = 32'h1f88_e6a5;
    blk_t                 blocks [$];                  // Newest first and at most three
    logic [ADDR_BITS-1:0] seen [$];                    // Recent fetch pcs kept across flush
    int                   n_hits = 0;
    int                   n_misses = 0;

    instr_decoder dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    task automatic check_equal(input string field, input logic [127:0] got,
                               input logic [127:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, field, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", field);
        end
    endtask

    // Newest block first and slot 0 before slot 1 as in the DUT search
    function automatic dec_slot_t expected_record(input logic [ADDR_BITS-1:0] npc,
                                                  output bit hit);
        slot_in_t  s;
        dec_slot_t r;
        hit = 1'b0;
        r   = DEC_EMPTY;
        foreach (blocks[b]) begin
            for (int k = 0; k < DEC_SLOTS; k++) begin
                s.pc    = blocks[b].pc + 32'(2 * k);
                s.bits  = blocks[b].win[16*k +: 32];
                s.fault = blocks[b].fault;
                if (!hit && s.pc == npc) begin
                    hit = 1'b1;
                    r   = ref_decode(s);
                end
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] rv32_word();
        logic [6:0]  opc [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                                  OPC_STORE, OPC_OP_IMM, OPC_OP, 7'b0001111, 7'b1110011};
        logic [31:0] x;
        int          idx;
        x      = $random(seed);
        idx    = {$random(seed)} % 11;
        x[6:0] = opc[idx];
        if (x[26]) begin
            x[31:25] = x[30] ? 7'h20 : 7'h00;          // Bias towards valid funct7
        end
        return x;
    endfunction

    // Quadrant and funct3 pairs with the last four outside the subset
    function automatic logic [15:0] rvc_half();
        logic [4:0]  tbl [10] = '{5'b000_01, 5'b010_01, 5'b010_00, 5'b110_00, 5'b101_01,
                                  5'b100_10, 5'b001_01, 5'b011_01, 5'b000_00, 5'b111_10};
        logic [15:0] c;
        int          idx;
        c        = 16'($random(seed));
        idx      = {$random(seed)} % 10;
        c[15:13] = tbl[idx][4:2];
        c[1:0]   = tbl[idx][1:0];
        return c;
    endfunction

    function automatic logic [FETCH_BITS-1:0] make_window();
        logic [FETCH_BITS-1:0] w;
        w = {$random(seed), $random(seed)};
        case ({$random(seed)} % 3)
            0: w[31:0] = rv32_word();
            1: w[31:0] = {rvc_half(), rvc_half()};
            default: w[47:0] = {rv32_word(), rvc_half()}; // Word straddles the halfword
        endcase
        return w;
    endfunction

    // Model update, probe choice and comparison once per edge
    initial begin : compare_proc
        dec_slot_t want;
        bit        want_hit;
        int        probe_k;
        probe_k = 0;
        i_e_npc <= '0;
        forever begin
            @(posedge i_clk);
            if (!i_nrst || i_flush) begin
                blocks.delete();
            end else if (blocks.size() == 0 || i_f_pc != blocks[0].pc) begin
                blocks.push_front(blk_t'{pc: i_f_pc, win: i_f_instr, fault: i_f_fault});
                if (blocks.size() > HIST_BLOCKS + 1) void'(blocks.pop_back());
                seen.push_front(i_f_pc);
                if (seen.size() > 6) void'(seen.pop_back());
            end
            probe_k++;
            if (seen.size() == 0) begin
                i_e_npc <= 32'h0000_0400 + 32'(4 * probe_k);
            end else begin
                i_e_npc <= seen[probe_k % seen.size()] + 32'(2 * ((probe_k / 7) % 2));
            end
            #5;
            want = expected_record(i_e_npc, want_hit);
            if (want_hit) n_hits++;
            else n_misses++;
            check_equal("o_hit", 128'(o_hit), 128'(want_hit));
            check_equal("pc", 128'(o_dec.pc), 128'(want.pc));
            check_equal("instr", 128'(o_dec.instr), 128'(want.instr));
            check_equal("compressed", 128'(o_dec.compressed), 128'(want.compressed));
            check_equal("op_class", 128'(o_dec.op_class), 128'(want.op_class));
            check_equal("rs1", 128'(o_dec.rs1), 128'(want.rs1));
            check_equal("rs2", 128'(o_dec.rs2), 128'(want.rs2));
            check_equal("rd", 128'(o_dec.rd), 128'(want.rd));
            check_equal("imm", 128'(o_dec.imm), 128'(want.imm));
            check_equal("mem_load", 128'(o_dec.mem_load), 128'(want.mem_load));
            check_equal("mem_store", 128'(o_dec.mem_store), 128'(want.mem_store));
            check_equal("mem_size", 128'(o_dec.mem_size), 128'(want.mem_size));
            check_equal("mem_unsigned", 128'(o_dec.mem_unsigned), 128'(want.mem_unsigned));
            check_equal("illegal", 128'(o_dec.illegal), 128'(want.illegal));
            check_equal("fault", 128'(o_dec.fault), 128'(want.fault));
        end
    end

    initial begin : stimulus
        logic [ADDR_BITS-1:0] pc;
        int                   hold;
        i_nrst    <= 1'b0;
        i_f_pc    <= '0;
        i_f_instr <= '0;
        i_f_fault <= 1'b0;
        i_flush   <= 1'b0;
        repeat (2) @(posedge i_clk);
        i_nrst  <= 1'b1;
        i_flush <= 1'b1;                               // Fetch at pc 0 is dropped
        repeat (2) @(posedge i_clk);
        pc = 32'h0000_1000;
        for (int n = 0; n < N_BLOCKS; n++) begin
            if (($random(seed) & 15) == 0) begin
                pc = {$random(seed)} & 32'h0000_fffe;  // Taken jump to a halfword aligned pc
            end
            hold = {$random(seed)} % 3;
            i_f_pc    <= pc;
            i_f_instr <= make_window();
            i_f_fault <= (($random(seed) & 7) == 0);
            i_flush   <= (($random(seed) & 31) == 0);
            @(posedge i_clk);
            // New window bits under a held pc must not be picked up
            for (int h = 0; h < hold; h++) begin
                i_flush   <= 1'b0;
                i_f_instr <= {$random(seed), $random(seed)};
                i_f_fault <= 1'($random(seed));
                @(posedge i_clk);
            end
            i_flush <= 1'b0;
            pc = pc + 32'd4;
        end
        repeat (4) @(posedge i_clk);
        if (n_hits == 0 || n_misses == 0) begin
            $display("Probes too one-sided: %0d hits and %0d misses", n_hits, n_misses);
            $display("=== FAIL ===");
            $fatal(1, "Probe coverage");
        end else begin
            $display("%0d hits and %0d misses compared", n_hits, n_misses);
            $display("=== PASS ===");
            $finish;
        end
    end

    initial begin : watchdog
        #((N_BLOCKS * 3 + 10) * 3 * CLK_NS);
        $display("Timeout: the stimulus did not finish in the expected time");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- tb.f
+incdir+include
src/dec_pkg.sv
src/fetch_slot_feeder.sv
src/slot_decoder.sv
src/decode_history.sv
src/instr_decoder.sv
bench/instr_decoder_props.sv
bench/tb_instr_decoder.sv

//--- run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and searches the log for the verdict

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_instr_decoder -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
    exit 0
fi
echo "No pass line found in $log"
exit 1
